// File: build.f
+incdir+include
hw/frv_front_pkg.sv
hw/frv_ifetch.sv
hw/frv_fetch_buffer.sv
hw/frv_decode_stage.sv
hw/frv_front.sv
testbench/frv_front_tb.sv

// File: Makefile
# Verilator build and run of the front end testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module frv_front_tb \
		-Mdir obj_dir -o frv_front_tb
	@out="$$(./obj_dir/frv_front_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: testbench/frv_front_tb.sv
/*
 * Front end testbench
 * Runs a small RV32I program through fetch, buffer and decode under random
 * memory stall and dispatch busy, with one fetch error and one redirect
 */
`timescale 1ns/10ps
`include "frv_front_config.svh"

module frv_front_tb;

    localparam int          NUM_ROWS  = 21;
    localparam int          RST_CYC   = 8;
    localparam int          TIMEOUT   = NUM_ROWS * 20 + RST_CYC; // In cycles
    localparam int          CF_ROW    = 14;                     // Last row on the old path
    localparam logic [31:0] BASE      = `FRV_PC_RESET_VALUE;
    localparam logic [31:0] CF_TARGET = BASE + 32'h100;
    localparam logic [31:0] ERR_ADDR  = BASE + 32'h2C;          // Fetch error here

    logic                    g_clk;
    logic                    i_rst_n;
    logic                    i_cf_req;
    frv_front_pkg::addr_t    i_cf_target;
    logic                    o_cf_ack;
    logic                    i_flush;
    logic                    o_imem_cen;
    frv_front_pkg::addr_t    o_imem_addr;
    logic                    i_imem_stall;
    frv_front_pkg::word_t    i_imem_rdata;
    logic                    i_imem_error;
    logic                    o_valid;
    logic                    i_busy;
    frv_front_pkg::reg_idx_t o_rd;
    frv_front_pkg::reg_idx_t o_rs1;
    frv_front_pkg::reg_idx_t o_rs2;
    frv_front_pkg::word_t    o_imm;
    frv_front_pkg::addr_t    o_pc;
    frv_front_pkg::uop_t     o_uop;
    frv_front_pkg::fu_t      o_fu;
    logic                    o_trap;
    frv_front_pkg::word_t    o_instr;

    // Program and expected decode, one row per instruction
    string                row_name [NUM_ROWS];
    logic [31:0]          row_addr [NUM_ROWS];
    logic [31:0]          row_word [NUM_ROWS];
    logic [31:0]          row_exp  [NUM_ROWS][7];   // rd rs1 rs2 imm uop fu trap
    string                field_name [7] = '{"rd", "rs1", "rs2", "imm", "uop", "fu", "trap"};
    frv_front_pkg::word_t imem [128];               // 512 bytes from BASE

    integer               seed;
    integer               r_val;
    int                   i;
    int                   row;          // Next expected output
    int                   n_rows;
    int                   cycle_cnt;
    int                   cf_state;     // 0 none, 1 requesting, 2 taken
    logic                 mem_acc;      // Request accepted at the coming edge
    frv_front_pkg::addr_t mem_addr;
    frv_front_pkg::addr_t next_addr;
    logic                 hold_due;     // Output must stay as it is
    logic [31:0]          hold_pc;
    logic [31:0]          hold_instr;

    frv_front u_dut (.*);

    always #10 g_clk = ~g_clk;          // 20 ns period

    // Compares expected against actual
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] word, input int rd,
                           input int rs1, input int rs2, input logic [31:0] imm,
                           input logic [4:0] uop, input logic [2:0] fu, input logic trap);
        row_name[n_rows] = name;
        row_addr[n_rows] = next_addr;
        row_word[n_rows] = word;
        row_exp[n_rows]  = '{rd, rs1, rs2, imm, 32'(uop), 32'(fu), 32'(trap)};
        next_addr        = next_addr + 32'd4;
        n_rows           = n_rows + 1;
    endtask

    // All fields of the taken output against one row
    task automatic check_row(input int r);
        logic [31:0] act [7];
        int          f;
        act = '{32'(o_rd), 32'(o_rs1), 32'(o_rs2), o_imm, 32'(o_uop), 32'(o_fu), 32'(o_trap)};
        check_value({row_name[r], " pc"}, row_addr[r], o_pc);
        check_value({row_name[r], " instr"}, row_word[r], o_instr);
        for (f = 0; f < 7; f++) begin
            check_value({row_name[r], " ", field_name[f]}, row_exp[r][f], act[f]);
        end
    endtask

    // Background pattern built from every address bit
    function automatic frv_front_pkg::word_t fill_word(input frv_front_pkg::addr_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic frv_front_pkg::word_t read_word(input frv_front_pkg::addr_t addr);
        if (addr[31:9] == BASE[31:9]) begin
            return imem[addr[8:2]];
        end else begin
            return fill_word(addr);                             // Outside the model
        end
    endfunction

    // ----------------------------------------
    // Timeout
    // ----------------------------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge g_clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout after %0d cycles with %0d of %0d outputs seen",
                 cycle_cnt, row, NUM_ROWS);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // ----------------------------------------
    // Stimulus and checking
    // ----------------------------------------
    initial begin
        g_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_cf_req     = 1'b0;
        i_cf_target  = '0;
        i_flush      = 1'b0;
        i_imem_stall = 1'b0;
        i_imem_rdata = '0;
        i_imem_error = 1'b0;
        i_busy       = 1'b0;
        seed         = 71922;
        row          = 0;
        n_rows       = 0;
        cf_state     = 0;
        hold_due     = 1'b0;
        hold_pc      = '0;
        hold_instr   = '0;
        mem_acc      = 1'b0;
        mem_addr     = '0;
        next_addr    = BASE;

        // name          word        rd  rs1 rs2 imm           uop    fu      trap
        add_row("addi",      32'h00500093, 1, 0, 0, 32'h0000_0005, 5'h00, 3'b001, 0);
        add_row("add",       32'h002081B3, 3, 1, 2, 32'h0000_0000, 5'h00, 3'b001, 0);
        add_row("sub",       32'h40118233, 4, 3, 1, 32'h0000_0000, 5'h08, 3'b001, 0);
        add_row("srai",      32'h40325293, 5, 4, 0, 32'h0000_0403, 5'h0D, 3'b001, 0);
        add_row("lw",        32'hFFC2A303, 6, 5, 0, 32'hFFFF_FFFC, 5'h02, 3'b010, 0);
        add_row("sw",        32'h00612423, 0, 2, 6, 32'h0000_0008, 5'h0A, 3'b010, 0);
        add_row("beq",       32'hFE208CE3, 0, 1, 2, 32'hFFFF_FFF8, 5'h00, 3'b100, 0);
        add_row("lui",       32'h123453B7, 7, 0, 0, 32'h1234_5000, 5'h10, 3'b001, 0);
        add_row("auipc",     32'hFFFFF417, 8, 0, 0, 32'hFFFF_F000, 5'h11, 3'b001, 0);
        add_row("jal",       32'h010000EF, 1, 0, 0, 32'h0000_0010, 5'h12, 3'b100, 0);
        add_row("jalr",      32'h00008067, 0, 1, 0, 32'h0000_0000, 5'h13, 3'b100, 0);
        add_row("fetch_err", 32'h00100093, 0, 0, 0, 32'h0, `FRV_UOP_TRAP_FETCH, 3'b000, 1);
        add_row("custom0",   32'h0000000B, 0, 0, 0, 32'h0, `FRV_UOP_TRAP_ILLEGAL, 3'b000, 1);
        add_row("half_word", 32'h00004501, 0, 0, 0, 32'h0, `FRV_UOP_TRAP_ILLEGAL, 3'b000, 1);
        add_row("mul",       32'h02310533, 0, 0, 0, 32'h0, `FRV_UOP_TRAP_ILLEGAL, 3'b000, 1);
        next_addr = CF_TARGET;                                  // Redirected path
        add_row("ori",       32'hFFF4E493, 9, 9, 0, 32'hFFFF_FFFF, 5'h06, 3'b001, 0);
        add_row("slli",      32'h01F49513, 10, 9, 0, 32'h0000_001F, 5'h01, 3'b001, 0);
        add_row("lbu",       32'h7FF54583, 11, 10, 0, 32'h0000_07FF, 5'h04, 3'b010, 0);
        add_row("sb",        32'hFEB50FA3, 0, 10, 11, 32'hFFFF_FFFF, 5'h08, 3'b010, 0);
        add_row("bne",       32'h00011663, 0, 2, 0, 32'h0000_000C, 5'h01, 3'b100, 0);
        add_row("xor",       32'h00A5C633, 12, 11, 10, 32'h0000_0000, 5'h04, 3'b001, 0);

        for (i = 0; i < 128; i++) begin
            imem[i] = fill_word(BASE + 32'(i * 4));
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            imem[row_addr[i][8:2]] = row_word[i];
        end

        repeat (RST_CYC / 2) @(posedge g_clk);
        check_value("reset o_imem_cen", 32'd0, 32'(o_imem_cen));
        #1 i_cf_req = 1'b1;                                     // Change request held in reset
        repeat (RST_CYC / 2) @(posedge g_clk);
        check_value("reset o_cf_ack", 32'd0, 32'(o_cf_ack));
        check_value("reset o_valid", 32'd0, 32'(o_valid));
        #1;
        i_rst_n  = 1'b1;
        i_cf_req = 1'b0;

        while (row < NUM_ROWS) begin
            @(negedge g_clk);                                   // Sample mid cycle
            mem_acc  = o_imem_cen & ~i_imem_stall;
            mem_addr = o_imem_addr;
            if (hold_due) begin
                check_value("hold o_valid", 32'd1, 32'(o_valid));
                check_value("hold o_pc", hold_pc, o_pc);
                check_value("hold o_instr", hold_instr, o_instr);
            end
            hold_due   = o_valid & i_busy & ~i_flush;
            hold_pc    = o_pc;
            hold_instr = o_instr;
            if (cf_state == 1 && o_cf_ack) begin
                cf_state = 2;                                   // PC loads target at this edge
            end
            if (o_valid && !i_busy && !i_flush) begin
                check_row(row);
                if (row == CF_ROW) begin
                    cf_state = 1;
                end
                row = row + 1;
            end

            @(posedge g_clk);
            #1;
            i_imem_rdata = mem_acc ? read_word(mem_addr) : '0;  // Answer one cycle later
            i_imem_error = mem_acc & (mem_addr == ERR_ADDR);
            r_val        = $random(seed);
            i_imem_stall = r_val[6:0] < 7'd38;                  // About 30 %
            r_val        = $random(seed);
            i_busy       = (r_val[6:0] < 7'd38) | (cf_state == 1);
            i_cf_req     = cf_state == 1;
            i_cf_target  = CF_TARGET;
            i_flush      = 1'b0;
            #1;
            i_flush = (cf_state == 1) & o_cf_ack;               // Flush in the ack cycle
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: hw/frv_front.sv
/*
 * Instruction front end
 * Fetch, fetch buffer and decode between instruction memory and dispatch
 */
`timescale 1ns/10ps
`include "frv_front_config.svh"

module frv_front (
    input  logic                    g_clk,        // Core clock
    input  logic                    i_rst_n,      // Async reset
    input  logic                    i_cf_req,     // Change request
    input  frv_front_pkg::addr_t    i_cf_target,  // Change target
    output logic                    o_cf_ack,     // Change taken
    input  logic                    i_flush,      // Drop buffered words
    output logic                    o_imem_cen,   // Read request
    output frv_front_pkg::addr_t    o_imem_addr,  // Read address
    input  logic                    i_imem_stall, // Memory stall
    input  frv_front_pkg::word_t    i_imem_rdata, // Read data
    input  logic                    i_imem_error, // Read error
    output logic                    o_valid,      // Decoded item ready
    input  logic                    i_busy,       // Dispatch stalled
    output frv_front_pkg::reg_idx_t o_rd,
    output frv_front_pkg::reg_idx_t o_rs1,
    output frv_front_pkg::reg_idx_t o_rs2,
    output frv_front_pkg::word_t    o_imm,
    output frv_front_pkg::addr_t    o_pc,
    output frv_front_pkg::uop_t     o_uop,
    output frv_front_pkg::fu_t      o_fu,
    output logic                    o_trap,
    output frv_front_pkg::word_t    o_instr
);

    // Fetch to buffer
    logic                                  push;
    frv_front_pkg::word_t                  push_data;
    frv_front_pkg::addr_t                  push_pc;
    logic                                  push_err;
    logic [$clog2(`FRV_FETCH_BUF_DEPTH):0] free;
    // Buffer to decode
    logic                                  pop;
    logic                                  head_valid;
    frv_front_pkg::word_t                  head_data;
    frv_front_pkg::addr_t                  head_pc;
    logic                                  head_err;

    frv_ifetch u_ifetch (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_cf_req     (i_cf_req),
        .i_cf_target  (i_cf_target),
        .o_cf_ack     (o_cf_ack),
        .i_imem_stall (i_imem_stall),
        .i_imem_rdata (i_imem_rdata),
        .i_imem_error (i_imem_error),
        .o_imem_cen   (o_imem_cen),
        .o_imem_addr  (o_imem_addr),
        .i_free       (free),
        .o_push       (push),
        .o_push_data  (push_data),
        .o_push_pc    (push_pc),
        .o_push_err   (push_err)
    );

    frv_fetch_buffer u_fetch_buffer (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_push       (push),
        .i_push_data  (push_data),
        .i_push_pc    (push_pc),
        .i_push_err   (push_err),
        .o_free       (free),
        .i_pop        (pop),
        .o_head_valid (head_valid),
        .o_head_data  (head_data),
        .o_head_pc    (head_pc),
        .o_head_err   (head_err)
    );

    frv_decode_stage u_decode (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_head_valid (head_valid),
        .i_head_data  (head_data),
        .i_head_pc    (head_pc),
        .i_head_err   (head_err),
        .o_pop        (pop),
        .i_busy       (i_busy),
        .o_valid      (o_valid),
        .o_rd         (o_rd),
        .o_rs1        (o_rs1),
        .o_rs2        (o_rs2),
        .o_imm        (o_imm),
        .o_pc         (o_pc),
        .o_uop        (o_uop),
        .o_fu         (o_fu),
        .o_trap       (o_trap),
        .o_instr      (o_instr)
    );

endmodule

// File: hw/frv_decode_stage.sv
/*
 * Decode stage
 * Decodes the buffer head into pipeline fields and holds them in a
 * valid/busy output register for dispatch
 */
`timescale 1ns/10ps
`include "frv_front_config.svh"

module frv_decode_stage (
    input  logic                    g_clk,        // Core clock
    input  logic                    i_rst_n,      // Async reset
    input  logic                    i_flush,      // Clear output valid
    input  logic                    i_head_valid, // Buffer head present
    input  frv_front_pkg::word_t    i_head_data,  // Head word
    input  frv_front_pkg::addr_t    i_head_pc,    // Head PC
    input  logic                    i_head_err,   // Head fetch error
    output logic                    o_pop,        // Head consumed
    input  logic                    i_busy,       // Dispatch stalled
    output logic                    o_valid,      // Output register full
    output frv_front_pkg::reg_idx_t o_rd,         // Destination register
    output frv_front_pkg::reg_idx_t o_rs1,        // Source register 1
    output frv_front_pkg::reg_idx_t o_rs2,        // Source register 2
    output frv_front_pkg::word_t    o_imm,        // Sign-extended immediate
    output frv_front_pkg::addr_t    o_pc,         // Instruction PC
    output frv_front_pkg::uop_t     o_uop,        // Micro-op
    output frv_front_pkg::fu_t      o_fu,         // Unit select
    output logic                    o_trap,       // Raise a trap
    output frv_front_pkg::word_t    o_instr       // Raw word
);

    localparam frv_front_pkg::fu_t FU_ALU = 3'b001;
    localparam frv_front_pkg::fu_t FU_MEM = 3'b010;
    localparam frv_front_pkg::fu_t FU_CF  = 3'b100;

    frv_front_pkg::word_t    instr;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic                    shift;     // OP-IMM shift encoding
    logic                    illegal;
    frv_front_pkg::reg_idx_t d_rd;
    frv_front_pkg::reg_idx_t d_rs1;
    frv_front_pkg::reg_idx_t d_rs2;
    frv_front_pkg::word_t    d_imm;
    frv_front_pkg::uop_t     d_uop;
    frv_front_pkg::fu_t      d_fu;
    logic                    d_trap;
    logic                    load_en;

    assign instr  = i_head_data;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign shift  = funct3[1:0] == 2'b01;

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    always_comb begin
        d_rd    = instr[11:7];
        d_rs1   = instr[19:15];
        d_rs2   = instr[24:20];
        d_imm   = {{20{instr[31]}}, instr[31:20]};                  // I-type default
        d_uop   = '0;
        d_fu    = '0;
        illegal = 1'b0;
        // Every known opcode ends in 11, so a 16-bit word falls to default
        case (instr[6:0])
            7'b0110111, 7'b0010111: begin                           // LUI, AUIPC
                d_rs1 = '0;
                d_rs2 = '0;
                d_imm = {instr[31:12], 12'h000};
                d_uop = instr[5] ? 5'h10 : 5'h11;
                d_fu  = FU_ALU;
            end
            7'b1101111: begin                                       // JAL
                d_rs1 = '0;
                d_rs2 = '0;
                d_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
                d_uop = 5'h12;
                d_fu  = FU_CF;
            end
            7'b1100111: begin                                       // JALR
                d_rs2   = '0;
                d_uop   = 5'h13;
                d_fu    = FU_CF;
                illegal = funct3 != 3'b000;
            end
            7'b1100011: begin                                       // BRANCH
                d_rd    = '0;
                d_imm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                d_uop   = {2'b00, funct3};
                d_fu    = FU_CF;
                illegal = funct3[2:1] == 2'b01;                     // No 010, 011
            end
            7'b0000011: begin                                       // LOAD
                d_rs2   = '0;
                d_uop   = {2'b00, funct3};
                d_fu    = FU_MEM;
                illegal = (funct3 == 3'b011) | (funct3[2:1] == 2'b11);
            end
            7'b0100011: begin                                       // STORE
                d_rd    = '0;
                d_imm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                d_uop   = {2'b01, funct3};                          // Bit 3 marks store
                d_fu    = FU_MEM;
                illegal = funct3[2] | (funct3[1:0] == 2'b11);
            end
            7'b0010011: begin                                       // OP-IMM
                d_rs2   = '0;
                d_uop   = {1'b0, shift & instr[30], funct3};        // Bit 30 only for shifts
                d_fu    = FU_ALU;
                illegal = shift & (((funct7 & 7'b1011111) != '0) |
                                   (funct3 == 3'b001 & instr[30]));
            end
            7'b0110011: begin                                       // OP
                d_imm   = '0;
                d_uop   = {1'b0, instr[30], funct3};
                d_fu    = FU_ALU;
                // Rejects the M extension and bad SUB/SRA forms
                illegal = ((funct7 & 7'b1011111) != '0) |
                          (instr[30] & funct3 != 3'b000 & funct3 != 3'b101);
            end
            default: illegal = 1'b1;
        endcase

        d_trap = i_head_err | illegal;
        if (d_trap) begin
            d_rd  = '0;
            d_rs1 = '0;
            d_rs2 = '0;
            d_imm = '0;
            d_fu  = '0;
            d_uop = i_head_err ? `FRV_UOP_TRAP_FETCH : `FRV_UOP_TRAP_ILLEGAL; // Error first
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    assign load_en = i_head_valid & (~o_valid | ~i_busy) & ~i_flush;
    assign o_pop   = load_en;

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;                    // Old path gone
        end else if (load_en) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                    // Taken, nothing behind it
        end
    end

    always_ff @(posedge g_clk) begin
        if (load_en) begin
            o_rd    <= d_rd;
            o_rs1   <= d_rs1;
            o_rs2   <= d_rs2;
            o_imm   <= d_imm;
            o_pc    <= i_head_pc;
            o_uop   <= d_uop;
            o_fu    <= d_fu;
            o_trap  <= d_trap;
            o_instr <= instr;
        end
    end

endmodule

// File: hw/frv_fetch_buffer.sv
/*
 * Fetch buffer
 * Circular FIFO of fetched word, PC and error bit, reports free entries
 */
`timescale 1ns/10ps
`include "frv_front_config.svh"

module frv_fetch_buffer (
    input  logic                                      g_clk,        // Core clock
    input  logic                                      i_rst_n,      // Async reset
    input  logic                                      i_flush,      // Drop all entries
    input  logic                                      i_push,       // Write entry
    input  frv_front_pkg::word_t                      i_push_data,  // Fetched word
    input  frv_front_pkg::addr_t                      i_push_pc,    // Its PC
    input  logic                                      i_push_err,   // Its error bit
    output logic [$clog2(`FRV_FETCH_BUF_DEPTH):0]     o_free,       // Empty slots
    input  logic                                      i_pop,        // Take head
    output logic                                      o_head_valid, // Head present
    output frv_front_pkg::word_t                      o_head_data,  // Head word
    output frv_front_pkg::addr_t                      o_head_pc,    // Head PC
    output logic                                      o_head_err    // Head error
);

    localparam int DEPTH = `FRV_FETCH_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    frv_front_pkg::word_t data_mem [DEPTH];     // Word storage
    frv_front_pkg::addr_t pc_mem [DEPTH];       // PC storage
    logic [DEPTH-1:0]     err_mem;              // Fetch error per entry
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;              // Entries held
    logic                 do_pop;

    assign o_head_valid = count_q != '0;
    assign o_free       = CNT_W'(DEPTH) - count_q;
    assign do_pop       = i_pop & o_head_valid;  // Ignore pop when empty

    assign o_head_data  = data_mem[rd_ptr_q];
    assign o_head_pc    = pc_mem[rd_ptr_q];
    assign o_head_err   = err_mem[rd_ptr_q];

    // Storage, the fetch side never pushes when full
    always_ff @(posedge g_clk) begin
        if (i_push) begin
            data_mem[wr_ptr_q] <= i_push_data;
            pc_mem[wr_ptr_q]   <= i_push_pc;
            err_mem[wr_ptr_q]  <= i_push_err;
        end
    end

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (i_flush) begin
            wr_ptr_q <= '0;                     // Flush beats a push
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(i_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: hw/frv_ifetch.sv
/*
 * Instruction fetch
 * Issues word reads, keeps the PC, takes control flow changes and
 * pushes responses into the fetch buffer
 */
`timescale 1ns/10ps
`include "frv_front_config.svh"

module frv_ifetch (
    input  logic                                      g_clk,        // Core clock
    input  logic                                      i_rst_n,      // Async reset
    input  logic                                      i_cf_req,     // Change request
    input  frv_front_pkg::addr_t                      i_cf_target,  // Change target
    output logic                                      o_cf_ack,     // Change taken
    input  logic                                      i_imem_stall, // Memory stall
    input  frv_front_pkg::word_t                      i_imem_rdata, // Read data
    input  logic                                      i_imem_error, // Read error
    output logic                                      o_imem_cen,   // Read request
    output frv_front_pkg::addr_t                      o_imem_addr,  // Read address
    input  logic [$clog2(`FRV_FETCH_BUF_DEPTH):0]     i_free,       // Buffer room
    output logic                                      o_push,       // Push word
    output frv_front_pkg::word_t                      o_push_data,  // Fetched word
    output frv_front_pkg::addr_t                      o_push_pc,    // Its PC
    output logic                                      o_push_err    // Its error bit
);

    localparam int CNT_W = $clog2(`FRV_FETCH_BUF_DEPTH) + 1;

    frv_front_pkg::fetch_state_t state_q;   // Response tracking
    frv_front_pkg::addr_t        pc_q;      // Next fetch PC
    frv_front_pkg::addr_t        rsp_pc_q;  // PC of the request in flight
    logic                        held_q;    // Request held by a stall
    logic                        room;      // Buffer can take one more
    logic                        req_acc;   // Request accepted this edge

    // ----------------------------------------
    // Request side
    // ----------------------------------------

    // A response due this cycle has a slot reserved already
    assign room = i_free > CNT_W'(state_q == frv_front_pkg::WAIT_RSP);

    // No change while a stalled request must hold
    assign o_cf_ack    = i_rst_n & i_cf_req & ~held_q;              // Low in reset
    assign o_imem_cen  = i_rst_n & (held_q | (room & ~i_cf_req));   // Low in reset
    assign o_imem_addr = pc_q;                          // Stable while held
    assign req_acc     = o_imem_cen & ~i_imem_stall;

    // ----------------------------------------
    // Response side
    // ----------------------------------------
    assign o_push      = (state_q == frv_front_pkg::WAIT_RSP) & ~o_cf_ack; // Old path
    assign o_push_data = i_imem_rdata;
    assign o_push_pc   = rsp_pc_q;
    assign o_push_err  = i_imem_error;

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= frv_front_pkg::IDLE;
            pc_q    <= `FRV_PC_RESET_VALUE;
            held_q  <= 1'b0;
        end else begin
            held_q <= o_imem_cen & i_imem_stall;        // Keep cen and addr up

            if (o_cf_ack) begin
                pc_q <= i_cf_target;                    // Redirect
            end else if (req_acc) begin
                pc_q <= pc_q + 32'd4;                   // Sequential
            end

            // Accepted while a change waits means old path
            if (req_acc) begin
                state_q <= i_cf_req ? frv_front_pkg::DROP_RSP : frv_front_pkg::WAIT_RSP;
            end else begin
                state_q <= frv_front_pkg::IDLE;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (req_acc) begin
            rsp_pc_q <= pc_q;                           // Tag for the response
        end
    end

endmodule

// File: hw/frv_front_pkg.sv
/*
 * Front end types
 * Word, address and decode field types, plus the fetch FSM states
 */
package frv_front_pkg;

    typedef logic [31:0] word_t;    // Instruction or data word
    typedef logic [31:0] addr_t;    // Byte address or PC
    typedef logic [4:0]  reg_idx_t; // Architectural register index
    typedef logic [4:0]  uop_t;     // Micro-op code

    // One-hot unit select
    // bit 0 ALU, bit 1 memory, bit 2 control flow
    typedef logic [2:0]  fu_t;

    typedef enum logic [1:0] {
        IDLE,       // No response due
        WAIT_RSP,   // Response due, push it
        DROP_RSP    // Response due but stale
    } fetch_state_t;

endpackage

// File: include/frv_front_config.svh
/*
 * Front end configuration
 * Reset PC, fetch buffer depth and the trap micro-op codes
 */
`ifndef FRV_FRONT_CONFIG_SVH
`define FRV_FRONT_CONFIG_SVH

// PC taken when reset is released
`define FRV_PC_RESET_VALUE 32'h8000_0000

// Fetch buffer entries, power of two, at least 2
`define FRV_FETCH_BUF_DEPTH 4

// Trap micro-ops, top of the uop space
`define FRV_UOP_TRAP_ILLEGAL 5'h1E
`define FRV_UOP_TRAP_FETCH   5'h1F

`endif
